/* logic/w5500_config.svh */
`ifndef W5500_CONFIG_SVH
`define W5500_CONFIG_SVH

// clk cycles per sck half period
`define W5500_SPI_HALF_DIV 2

`define W5500_TX_FIFO_DEPTH 128

// socket 0 tx memory, 2 KB
`define W5500_TX_MEM_SIZE 2048

`define W5500_INIT_ENTRIES 12

`endif

/* logic/spi_frame_pkg.sv */
package spi_frame_pkg;

  // one W5500 frame: 16 bit address, control byte, data length
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  ctrl;
    logic [10:0] len;   // data bytes, never zero
  } spi_frame_req_t;

  // one data byte finished
  typedef struct packed {
    logic       byte_done;
    logic       last;       // final data byte of the frame
    logic [7:0] rdata;
  } spi_frame_rsp_t;

endpackage

/* logic/w5500_pkg.sv */
package w5500_pkg;

  // socket register offsets
  localparam logic [15:0] REG_SN_TX_WR = 16'h0024;
  localparam logic [15:0] REG_SN_CR    = 16'h0001;

  // control bytes, variable length mode
  localparam logic [7:0] CTRL_COMMON_WR = 8'h04;
  localparam logic [7:0] CTRL_SOCK_WR   = 8'h0C;
  localparam logic [7:0] CTRL_SOCK_RD   = 8'h08;
  localparam logic [7:0] CTRL_TXBUF_WR  = 8'h14;  // socket 0 tx buffer block

  localparam logic [7:0] CMD_SEND = 8'h20;

  // one configuration write, data[0] goes out first
  typedef struct packed {
    logic [15:0]     addr;
    logic [7:0]      ctrl;
    logic [2:0]      len;   // 1 to 6
    logic [0:5][7:0] data;
  } w5500_init_entry_t;

endpackage

/* logic/spi_byte_master.sv */
`include "w5500_config.svh"

module spi_byte_master (
  input  logic       clk,
  input  logic       rstn,
  input  logic       start,
  input  logic [7:0] wbyte,
  output logic       done,
  output logic [7:0] rbyte,
  output logic       sck,
  output logic       mosi,
  input  logic       miso
);
  localparam int HALF_DIV = `W5500_SPI_HALF_DIV;

  logic       active;
  logic [7:0] half_cnt;
  logic [2:0] bit_cnt;
  logic [7:0] tx_sh;
  logic       half_end;

  assign half_end = active && (half_cnt == 8'(HALF_DIV - 1));
  assign mosi     = tx_sh[7];  // msb first

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      active   <= 1'b0;
      half_cnt <= 8'd0;
      bit_cnt  <= 3'd0;
      sck      <= 1'b0;
      tx_sh    <= 8'd0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !active) begin
        active   <= 1'b1;
        half_cnt <= 8'd0;
        bit_cnt  <= 3'd0;
        tx_sh    <= wbyte;  // first bit valid before first rise
      end else if (active) begin
        half_cnt <= half_end ? 8'd0 : half_cnt + 8'd1;
        if (half_end) begin
          sck <= ~sck;
          // falling edge, next bit out
          if (sck) begin
            tx_sh   <= {tx_sh[6:0], 1'b0};
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              active <= 1'b0;
              done   <= 1'b1;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (half_end && !sck) rbyte <= {rbyte[6:0], miso};  // sample on rise
  end

endmodule

/* logic/w5500_frame_engine.sv */
module w5500_frame_engine import spi_frame_pkg::*; (
  input  logic           clk,
  input  logic           rstn,
  input  spi_frame_req_t req,
  input  logic           req_valid,
  output logic           req_ready,
  input  logic [7:0]     wdata,
  output spi_frame_rsp_t rsp,
  output logic           cs,
  output logic           sck,
  output logic           mosi,
  input  logic           miso
);
  typedef enum logic [2:0] {S_IDLE, S_LOAD, S_XFER, S_NEXT, S_GAP} state_t;

  state_t         state;
  spi_frame_req_t frame;
  logic [1:0]     phase;    // 0 addr hi, 1 addr lo, 2 ctrl, 3 data
  logic [10:0]    remain;   // data bytes left incl. current
  logic [7:0]     wbuf;
  logic [7:0]     tx_byte;
  logic           bm_done;
  logic [7:0]     bm_rbyte;
  logic           data_done;

  assign req_ready = (state == S_IDLE);

  always_comb begin
    case (phase)
      2'd0:    tx_byte = frame.addr[15:8];
      2'd1:    tx_byte = frame.addr[7:0];
      2'd2:    tx_byte = frame.ctrl;
      default: tx_byte = wbuf;
    endcase
  end

  // header bytes are not reported
  assign data_done     = (state == S_XFER) && bm_done && (phase == 2'd3);
  assign rsp.byte_done = data_done;
  assign rsp.last      = data_done && (remain == 11'd1);
  assign rsp.rdata     = bm_rbyte;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state  <= S_IDLE;
      cs     <= 1'b1;
      phase  <= 2'd0;
      remain <= 11'd0;
    end else begin
      case (state)
        S_IDLE: if (req_valid) begin
          cs     <= 1'b0;
          phase  <= 2'd0;
          remain <= req.len;
          state  <= S_LOAD;
        end
        S_LOAD: state <= S_XFER;
        S_XFER: if (bm_done) begin
          if (phase != 2'd3) begin
            phase <= phase + 2'd1;
            state <= S_LOAD;
          end else if (remain == 11'd1) begin
            cs    <= 1'b1;  // frame ends
            state <= S_GAP;
          end else begin
            remain <= remain - 11'd1;
            state  <= S_NEXT;  // owner updates wdata here
          end
        end
        S_NEXT: state <= S_LOAD;
        S_GAP:  state <= S_IDLE;  // keeps cs high two cycles
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && req_valid) begin
      frame <= req;
      wbuf  <= wdata;
    end else if (state == S_NEXT) begin
      wbuf <= wdata;
    end
  end

  spi_byte_master u_byte (
    .clk   (clk),
    .rstn  (rstn),
    .start (state == S_LOAD),
    .wbyte (tx_byte),
    .done  (bm_done),
    .rbyte (bm_rbyte),
    .sck   (sck),
    .mosi  (mosi),
    .miso  (miso)
  );

endmodule

/* logic/frame_arbiter.sv */
module frame_arbiter import spi_frame_pkg::*; (
  input  logic           clk,
  input  logic           rstn,
  input  spi_frame_req_t init_req,
  input  logic           init_req_valid,
  output logic           init_req_ready,
  input  logic [7:0]     init_wdata,
  output spi_frame_rsp_t init_rsp,
  input  spi_frame_req_t tx_req,
  input  logic           tx_req_valid,
  output logic           tx_req_ready,
  input  logic [7:0]     tx_wdata,
  output spi_frame_rsp_t tx_rsp,
  output spi_frame_req_t eng_req,
  output logic           eng_req_valid,
  input  logic           eng_req_ready,
  output logic [7:0]     eng_wdata,
  input  spi_frame_rsp_t eng_rsp
);
  logic locked;    // frame in flight
  logic owner_tx;
  logic sel_tx;

  // init has fixed priority while unlocked
  assign sel_tx = locked ? owner_tx : !init_req_valid;

  assign eng_req        = sel_tx ? tx_req : init_req;
  assign eng_wdata      = sel_tx ? tx_wdata : init_wdata;
  assign eng_req_valid  = !locked && (init_req_valid || tx_req_valid);
  assign init_req_ready = !locked && eng_req_ready && !sel_tx;
  assign tx_req_ready   = !locked && eng_req_ready && sel_tx;

  assign init_rsp = (locked && !owner_tx) ? eng_rsp : '0;
  assign tx_rsp   = (locked && owner_tx) ? eng_rsp : '0;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      locked   <= 1'b0;
      owner_tx <= 1'b0;
    end else if (eng_req_valid && eng_req_ready) begin
      locked   <= 1'b1;
      owner_tx <= sel_tx;
    end else if (eng_rsp.byte_done && eng_rsp.last) begin
      locked <= 1'b0;
    end
  end

endmodule

/* logic/init_sequencer.sv */
`include "w5500_config.svh"

module init_sequencer import spi_frame_pkg::*, w5500_pkg::*; (
  input  logic           clk,
  input  logic           rstn,
  output spi_frame_req_t req,
  output logic           req_valid,
  input  logic           req_ready,
  output logic [7:0]     wdata,
  input  spi_frame_rsp_t rsp,
  output logic           init_done
);
  localparam int N  = `W5500_INIT_ENTRIES;
  localparam int IW = $clog2(N);

  localparam w5500_init_entry_t TABLE [N] = '{
    '{16'h0001, CTRL_COMMON_WR, 3'd4, 48'hc0a8_0101_0000},  // gateway 192.168.1.1
    '{16'h0005, CTRL_COMMON_WR, 3'd4, 48'hffff_ff00_0000},  // subnet mask
    '{16'h0009, CTRL_COMMON_WR, 3'd6, 48'h0c29_ab7c_0001},  // mac
    '{16'h000f, CTRL_COMMON_WR, 3'd4, 48'hc0a8_01c7_0000},  // local ip .199
    '{16'h001e, CTRL_SOCK_WR,   3'd1, 48'h0200_0000_0000},  // rx buf 2 KB
    '{16'h001f, CTRL_SOCK_WR,   3'd1, 48'h0200_0000_0000},  // tx buf 2 KB
    '{16'h0012, CTRL_SOCK_WR,   3'd2, 48'h05b4_0000_0000},  // mss 1460
    '{16'h0004, CTRL_SOCK_WR,   3'd2, 48'h1388_0000_0000},  // port 5000
    '{16'h0000, CTRL_SOCK_WR,   3'd1, 48'h0200_0000_0000},  // udp mode
    '{16'h0001, CTRL_SOCK_WR,   3'd1, 48'h0100_0000_0000},  // open
    '{16'h000c, CTRL_SOCK_WR,   3'd4, 48'hc0a8_01be_0000},  // dest ip .190
    '{16'h0010, CTRL_SOCK_WR,   3'd2, 48'h1770_0000_0000}   // dest port 6000
  };

  typedef enum logic [1:0] {S_START, S_REQ, S_WAIT, S_DONE} state_t;

  state_t        state;
  logic [IW-1:0] ent_idx;
  logic [2:0]    byte_idx;

  assign req.addr  = TABLE[ent_idx].addr;
  assign req.ctrl  = TABLE[ent_idx].ctrl;
  assign req.len   = 11'(TABLE[ent_idx].len);
  assign req_valid = (state == S_REQ);
  assign wdata     = TABLE[ent_idx].data[byte_idx];
  assign init_done = (state == S_DONE);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= S_START;
      ent_idx  <= '0;
      byte_idx <= 3'd0;
    end else begin
      case (state)
        S_START: state <= S_REQ;
        S_REQ:   if (req_ready) state <= S_WAIT;
        S_WAIT: if (rsp.byte_done) begin
          byte_idx <= byte_idx + 3'd1;
          if (rsp.last) begin
            byte_idx <= 3'd0;
            if (ent_idx == IW'(N - 1)) begin
              state <= S_DONE;
            end else begin
              ent_idx <= ent_idx + 1'b1;
              state   <= S_REQ;
            end
          end
        end
        default: state <= S_DONE;  // table written, stay here
      endcase
    end
  end

endmodule

/* logic/tx_byte_fifo.sv */
`include "w5500_config.svh"

module tx_byte_fifo (
  input  logic       clk,
  input  logic       rstn,
  input  logic [7:0] push_data,
  input  logic       push,
  input  logic       pop,
  output logic [7:0] pop_data,
  output logic [7:0] count,
  output logic       full
);
  localparam int DEPTH = `W5500_TX_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  logic [7:0]    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  assign full     = (count == 8'(DEPTH));
  assign do_push  = push && !full;
  assign do_pop   = pop && (count != 8'd0);
  assign pop_data = mem[rd_ptr];  // head always visible

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 8'd0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + 8'(do_push) - 8'(do_pop);
    end
  end

endmodule

/* logic/udp_tx_sequencer.sv */
`include "w5500_config.svh"

module udp_tx_sequencer import spi_frame_pkg::*, w5500_pkg::*; (
  input  logic           clk,
  input  logic           rstn,
  input  logic           tx_start,
  input  logic [7:0]     fifo_count,
  output logic           pop,
  input  logic [7:0]     pop_data,
  output spi_frame_req_t req,
  output logic           req_valid,
  input  logic           req_ready,
  output logic [7:0]     wdata,
  input  spi_frame_rsp_t rsp,
  output logic           busy_tx
);
  localparam int MEM_SIZE = `W5500_TX_MEM_SIZE;
  localparam int MEM_AW   = $clog2(MEM_SIZE);

  typedef enum logic [2:0] {ST_IDLE, ST_RD, ST_WR, ST_PTR, ST_CMD} state_t;

  state_t          state;
  logic            tx_start_q;
  logic            start_edge;
  logic            start_pend;  // edge seen during a packet
  logic [7:0]      left;        // bytes still to write
  logic [15:0]     ptr;         // Sn_TX_WR copy
  logic            bsel;        // low byte of pointer write
  logic [MEM_AW:0] space;       // room up to the 2 KB boundary
  logic [10:0]     frame_len;

  assign start_edge = tx_start && !tx_start_q;
  assign busy_tx    = (state != ST_IDLE);
  assign pop        = (state == ST_WR) && rsp.byte_done;

  assign space     = (MEM_AW + 1)'(MEM_SIZE) - (MEM_AW + 1)'(ptr[MEM_AW-1:0]);
  assign frame_len = (space < (MEM_AW + 1)'(left)) ? 11'(space) : 11'(left);

  always_comb begin
    req   = '{addr: REG_SN_TX_WR, ctrl: CTRL_SOCK_RD, len: 11'd2};
    wdata = 8'h00;
    case (state)
      ST_WR: begin
        req   = '{addr: 16'(ptr[MEM_AW-1:0]), ctrl: CTRL_TXBUF_WR, len: frame_len};
        wdata = pop_data;
      end
      ST_PTR: begin
        req   = '{addr: REG_SN_TX_WR, ctrl: CTRL_SOCK_WR, len: 11'd2};
        wdata = bsel ? ptr[7:0] : ptr[15:8];  // msb first
      end
      ST_CMD: begin
        req   = '{addr: REG_SN_CR, ctrl: CTRL_SOCK_WR, len: 11'd1};
        wdata = CMD_SEND;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= ST_IDLE;
      req_valid  <= 1'b0;
      tx_start_q <= 1'b0;
      start_pend <= 1'b0;
      left       <= 8'd0;
      ptr        <= 16'd0;
      bsel       <= 1'b0;
    end else begin
      tx_start_q <= tx_start;
      if (req_valid && req_ready) req_valid <= 1'b0;
      if (start_edge && state != ST_IDLE) start_pend <= 1'b1;
      case (state)
        ST_IDLE: if (start_edge || start_pend) begin
          start_pend <= 1'b0;
          // empty buffer drops the request
          if (fifo_count != 8'd0) begin
            left      <= fifo_count;
            state     <= ST_RD;
            req_valid <= 1'b1;
          end
        end
        ST_RD: if (rsp.byte_done) begin
          ptr <= {ptr[7:0], rsp.rdata};
          if (rsp.last) begin
            state     <= ST_WR;
            req_valid <= 1'b1;
          end
        end
        ST_WR: if (rsp.byte_done) begin
          left <= left - 8'd1;
          ptr  <= ptr + 16'd1;
          if (rsp.last) begin
            // second frame after a 2 KB wrap
            state     <= (left == 8'd1) ? ST_PTR : ST_WR;
            req_valid <= 1'b1;
          end
        end
        ST_PTR: if (rsp.byte_done) begin
          bsel <= 1'b1;
          if (rsp.last) begin
            bsel      <= 1'b0;
            state     <= ST_CMD;
            req_valid <= 1'b1;
          end
        end
        ST_CMD: if (rsp.last) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* logic/w5500_udp_tx.sv */
module w5500_udp_tx import spi_frame_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic [7:0] tx_data,
  input  logic       tx_valid,
  output logic       tx_ready,
  input  logic       tx_start,
  output logic       busy,
  output logic       init_done,
  output logic       cs,
  output logic       sck,
  output logic       mosi,
  input  logic       miso
);
  spi_frame_req_t init_req, tx_req, eng_req;
  spi_frame_rsp_t init_rsp, tx_rsp, eng_rsp;
  logic           init_valid, init_ready;
  logic           seq_valid, seq_ready;
  logic           eng_valid, eng_ready;
  logic [7:0]     init_wdata, seq_wdata, eng_wdata;
  logic [7:0]     pop_data, fifo_count;
  logic           pop, full, busy_tx;

  // stream only accepted between packets
  assign tx_ready = init_done && !busy_tx && !full;
  assign busy     = !init_done || busy_tx;

  init_sequencer u_init (
    .clk(clk), .rstn(rstn),
    .req(init_req), .req_valid(init_valid), .req_ready(init_ready),
    .wdata(init_wdata), .rsp(init_rsp), .init_done(init_done)
  );

  tx_byte_fifo u_fifo (
    .clk(clk), .rstn(rstn),
    .push_data(tx_data), .push(tx_valid && tx_ready), .pop(pop),
    .pop_data(pop_data), .count(fifo_count), .full(full)
  );

  udp_tx_sequencer u_tx_seq (
    .clk(clk), .rstn(rstn), .tx_start(tx_start),
    .fifo_count(fifo_count), .pop(pop), .pop_data(pop_data),
    .req(tx_req), .req_valid(seq_valid), .req_ready(seq_ready),
    .wdata(seq_wdata), .rsp(tx_rsp), .busy_tx(busy_tx)
  );

  frame_arbiter u_arb (
    .clk(clk), .rstn(rstn),
    .init_req(init_req), .init_req_valid(init_valid), .init_req_ready(init_ready),
    .init_wdata(init_wdata), .init_rsp(init_rsp),
    .tx_req(tx_req), .tx_req_valid(seq_valid), .tx_req_ready(seq_ready),
    .tx_wdata(seq_wdata), .tx_rsp(tx_rsp),
    .eng_req(eng_req), .eng_req_valid(eng_valid), .eng_req_ready(eng_ready),
    .eng_wdata(eng_wdata), .eng_rsp(eng_rsp)
  );

  w5500_frame_engine u_engine (
    .clk(clk), .rstn(rstn),
    .req(eng_req), .req_valid(eng_valid), .req_ready(eng_ready),
    .wdata(eng_wdata), .rsp(eng_rsp),
    .cs(cs), .sck(sck), .mosi(mosi), .miso(miso)
  );

endmodule

/* test/w5500_spi_model.sv */
module w5500_spi_model import spi_frame_pkg::*; (
  input  logic        rstn,
  input  logic [15:0] ptr_init,
  input  logic        cs,
  input  logic        sck,
  input  logic        mosi,
  output logic        miso
);
  timeunit 1ns;
  timeprecision 1ps;

  spi_frame_req_t frames [$];  // one entry per cs low period
  logic [7:0]     data_q [$];  // data bytes of all frames, in order
  logic [15:0]    tx_wr;       // socket 0 Sn_TX_WR
  logic [15:0]    addr;
  logic [7:0]     ctrl;
  logic [7:0]     sh_in;
  logic [7:0]     sh_out;
  logic [7:0]     d_hi;
  logic [7:0]     d_lo;
  logic           out_bit;
  spi_frame_req_t rec;
  int             bit_pos;
  int             byte_cnt;

  assign miso = out_bit;

  initial begin
    out_bit = 1'b0;
    @(posedge rstn);
    tx_wr = ptr_init;
    forever begin
      @(negedge cs);
      bit_pos  = 0;
      byte_cnt = 0;
      sh_out   = 8'h00;
      while (!cs) begin
        @(sck or cs);
        if (!cs && sck) begin
          sh_in = {sh_in[6:0], mosi};  // mode 0, capture on rise
          bit_pos++;
          if (bit_pos == 8) begin
            bit_pos = 0;
            case (byte_cnt)
              0:       addr[15:8] = sh_in;
              1:       addr[7:0]  = sh_in;
              2:       ctrl       = sh_in;
              default: data_q.push_back(sh_in);
            endcase
            if (byte_cnt == 3) d_hi = sh_in;
            if (byte_cnt == 4) d_lo = sh_in;
            byte_cnt++;
          end
        end else if (!cs) begin
          // byte boundary, pick what the chip answers
          if (bit_pos == 0) begin
            sh_out = 8'h00;
            if (ctrl == 8'h08 && addr == 16'h0024 && byte_cnt == 3) sh_out = tx_wr[15:8];
            if (ctrl == 8'h08 && addr == 16'h0024 && byte_cnt == 4) sh_out = tx_wr[7:0];
          end
          out_bit = sh_out[7];
          sh_out  = {sh_out[6:0], 1'b0};
        end
      end
      if (byte_cnt > 3) begin
        rec.addr = addr;
        rec.ctrl = ctrl;
        rec.len  = 11'(byte_cnt - 3);
        frames.push_back(rec);
        // socket register write of the tx pointer
        if (ctrl == 8'h0C && addr == 16'h0024 && byte_cnt == 5) tx_wr = {d_hi, d_lo};
      end
    end
  end

endmodule

/* test/tb_w5500_udp_tx.sv */
`include "w5500_config.svh"

module tb_w5500_udp_tx
  import spi_frame_pkg::*, w5500_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PACKETS    = 6;
  localparam int DEPTH      = `W5500_TX_FIFO_DEPTH;
  localparam int MEM        = `W5500_TX_MEM_SIZE;
  localparam int INIT_BYTES = 68;  // 12 headers of 3 plus 32 data bytes
  localparam int MAX_CYCLES = (INIT_BYTES + PACKETS * 140) * 16 * `W5500_SPI_HALF_DIV * 2 + 2000;

  // configuration the chip must receive, in order
  localparam w5500_init_entry_t CFG [`W5500_INIT_ENTRIES] = '{
    '{16'h0001, 8'h04, 3'd4, {8'd192, 8'd168, 8'd1, 8'd1, 16'd0}},
    '{16'h0005, 8'h04, 3'd4, {8'd255, 8'd255, 8'd255, 8'd0, 16'd0}},
    '{16'h0009, 8'h04, 3'd6, {8'h0c, 8'h29, 8'hab, 8'h7c, 8'h00, 8'h01}},
    '{16'h000f, 8'h04, 3'd4, {8'd192, 8'd168, 8'd1, 8'd199, 16'd0}},
    '{16'h001e, 8'h0C, 3'd1, {8'd2, 40'd0}},
    '{16'h001f, 8'h0C, 3'd1, {8'd2, 40'd0}},
    '{16'h0012, 8'h0C, 3'd2, {16'd1460, 32'd0}},
    '{16'h0004, 8'h0C, 3'd2, {16'd5000, 32'd0}},
    '{16'h0000, 8'h0C, 3'd1, {8'h02, 40'd0}},   // udp
    '{16'h0001, 8'h0C, 3'd1, {8'h01, 40'd0}},   // open
    '{16'h000c, 8'h0C, 3'd4, {8'd192, 8'd168, 8'd1, 8'd190, 16'd0}},
    '{16'h0010, 8'h0C, 3'd2, {16'd6000, 32'd0}}
  };

  logic        clk;
  logic        rstn;
  logic [7:0]  tx_data;
  logic        tx_valid;
  logic        tx_ready;
  logic        tx_start;
  logic        busy;
  logic        init_done;
  logic        cs;
  logic        sck;
  logic        mosi;
  logic        miso;
  logic [15:0] ptr_init;
  logic [15:0] exp_ptr;  // expected Sn_TX_WR
  logic [31:0] rng;
  logic [7:0]  sent [$];
  int          buf_cnt;  // bytes waiting in the DUT buffer
  int          fidx;
  int          didx;
  int          cycles;

  w5500_udp_tx UUT (
    .clk(clk), .rstn(rstn),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
    .tx_start(tx_start), .busy(busy), .init_done(init_done),
    .cs(cs), .sck(sck), .mosi(mosi), .miso(miso)
  );

  w5500_spi_model u_model (
    .rstn(rstn), .ptr_init(ptr_init),
    .cs(cs), .sck(sck), .mosi(mosi), .miso(miso)
  );

  always #4 clk = ~clk;

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else
      fail_now($sformatf("error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // called right after a rising edge, returns on the edge that took the byte
  task automatic send_byte(input logic [7:0] b);
    logic taken;
    taken = 1'b0;
    tx_valid <= 1'b1;
    tx_data  <= b;
    while (!taken) begin
      @(negedge clk);
      taken = tx_ready;
      @(posedge clk);
    end
    sent.push_back(b);
    buf_cnt++;
  endtask

  task automatic expect_frame(input logic [15:0] addr, input logic [7:0] ctrl, input int len);
    spi_frame_req_t f;
    if (fidx >= u_model.frames.size()) begin
      fail_now($sformatf("frame %0d was expected but the SPI model saw none", fidx));
    end else begin
      f = u_model.frames[fidx];
      fidx++;
      check_eq("frame addr", 32'(f.addr), 32'(addr));
      check_eq("frame ctrl", 32'(f.ctrl), 32'(ctrl));
      check_eq("frame len", 32'(f.len), 32'(len));
    end
  endtask

  task automatic expect_data(input logic [7:0] exp, input string name);
    check_eq(name, 32'(u_model.data_q[didx]), 32'(exp));
    didx++;
  endtask

  task automatic check_init();
    logic [3:0] e;
    logic [2:0] j;
    check_eq("frames at init_done", 32'(u_model.frames.size()), 32'(`W5500_INIT_ENTRIES));
    for (e = 4'd0; e < 4'(`W5500_INIT_ENTRIES); e++) begin
      expect_frame(CFG[e].addr, CFG[e].ctrl, int'(CFG[e].len));
      for (j = 3'd0; j < CFG[e].len; j++) expect_data(CFG[e].data[j], "init data");
    end
  endtask

  task automatic run_packet(input int n, input bit overfill);
    int off;
    int first;
    sent.delete();
    for (int i = 0; i < n; i++) begin
      rng = xorshift(rng);
      send_byte(rng[7:0]);
    end
    if (overfill) begin
      tx_data <= 8'hee;  // extra byte that must be refused
      repeat (20) begin
        @(negedge clk);
        check_eq("tx_ready when full", 32'(tx_ready), 32'd0);
        @(posedge clk);
      end
    end
    tx_valid <= 1'b0;
    tx_start <= 1'b1;
    @(posedge clk);
    tx_start <= 1'b0;
    @(negedge clk);
    while (!busy) @(negedge clk);
    buf_cnt = 0;
    while (busy) @(negedge clk);

    expect_frame(16'h0024, 8'h08, 2);
    didx += 2;  // dummy bytes of the pointer read
    off   = int'(exp_ptr) % MEM;
    first = (n < MEM - off) ? n : MEM - off;
    expect_frame(16'(off), 8'h14, first);
    for (int i = 0; i < first; i++) expect_data(sent[i], "tx memory byte");
    if (first < n) begin
      expect_frame(16'h0000, 8'h14, n - first);  // wrapped part
      for (int i = first; i < n; i++) expect_data(sent[i], "tx memory byte");
    end
    exp_ptr = exp_ptr + 16'(n);
    expect_frame(16'h0024, 8'h0C, 2);
    expect_data(exp_ptr[15:8], "Sn_TX_WR high");
    expect_data(exp_ptr[7:0], "Sn_TX_WR low");
    expect_frame(16'h0001, 8'h0C, 1);
    expect_data(8'h20, "Sn_CR");
    @(posedge clk);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES)
      fail_now($sformatf("timeout after %0d cycles, the DUT did not finish", cycles));
  end

  // stream flags checked every cycle away from the edges
  always @(negedge clk) begin
    if (rstn) begin
      if (!init_done) check_eq("busy", 32'(busy), 32'd1);
      if (busy) check_eq("tx_ready", 32'(tx_ready), 32'd0);
      else check_eq("tx_ready", 32'(tx_ready), 32'(buf_cnt < DEPTH));
    end
  end

  initial begin
    clk      = 1'b0;
    rstn     = 1'b0;
    tx_data  = 8'h00;
    tx_valid = 1'b0;
    tx_start = 1'b0;
    buf_cnt  = 0;
    fidx     = 0;
    didx     = 0;
    rng      = xorshift(32'd77399);
    ptr_init = {rng[15:11], 11'd2047 - 11'(rng[4:0])};  // just below a 2 KB boundary
    exp_ptr  = ptr_init;
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_eq("cs", 32'(cs), 32'd1);
    check_eq("init_done", 32'(init_done), 32'd0);
    @(posedge clk);
    rstn <= 1'b1;
    while (!init_done) @(negedge clk);
    check_init();
    @(posedge clk);
    for (int p = 0; p < PACKETS; p++) begin
      rng = xorshift(rng);
      if (p == 2) run_packet(DEPTH, 1'b1);
      else run_packet(int'(rng[6:0]) + 1, 1'b0);
    end
    check_eq("frame count", 32'(u_model.frames.size()), 32'(fidx));
    $display("Simulation passed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+logic
logic/spi_frame_pkg.sv
logic/w5500_pkg.sv
logic/spi_byte_master.sv
logic/w5500_frame_engine.sv
logic/frame_arbiter.sv
logic/init_sequencer.sv
logic/tx_byte_fifo.sv
logic/udp_tx_sequencer.sv
logic/w5500_udp_tx.sv
test/w5500_spi_model.sv
test/tb_w5500_udp_tx.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f flist.f \
  --top-module tb_w5500_udp_tx -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
grep -q "Simulation passed" sim.log
